/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // ****************************************
    // widths
    // ****************************************
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // opcodes, anything else is a no-op
    typedef enum logic [4:0] {
        op_rtype = 5'b00000,
        op_j     = 5'b00001,
        op_bne   = 5'b00010,
        op_jal   = 5'b00011,
        op_addi  = 5'b00101,
        op_sw    = 5'b00111,
        op_lw    = 5'b01000
    } opcode_e;

    // alu codes in the R-type aluop field
    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    // ****************************************
    // instruction fields
    // ****************************************
    localparam int fld_op_hi    = 31;
    localparam int fld_op_lo    = 27;
    localparam int fld_rd_hi    = 26;
    localparam int fld_rd_lo    = 22;
    localparam int fld_rs_hi    = 21;
    localparam int fld_rs_lo    = 17;
    localparam int fld_rt_hi    = 16;
    localparam int fld_rt_lo    = 12;
    localparam int fld_shamt_hi = 11;
    localparam int fld_shamt_lo = 7;
    localparam int fld_alu_hi   = 6;
    localparam int fld_alu_lo   = 2;
    // immediate and jump target both start at bit 0
    localparam int fld_imm_hi   = 15;
    localparam int fld_tgt_hi   = 26;

    // jal return address goes here
    localparam reg_addr_t link_reg = 5'd31;

    // ****************************************
    // pipeline registers
    // ****************************************
    typedef struct packed {
        logic is_rtype;
        logic is_addi;
        logic is_lw;
        logic is_sw;
        logic is_bne;
        logic is_jal;
        logic reg_write;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc_plus_1;
        word_t instr;
    } fd_t;

    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        word_t      pc_plus_1;
        reg_addr_t  rd;
        reg_addr_t  rs_num;
        reg_addr_t  reg2_num;
        word_t      rs_val;
        word_t      reg2_val;
        word_t      imm;
        alu_op_e    alu_op;
        logic [4:0] shamt;
    } dx_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        reg_addr_t rd;
        word_t     result;
        word_t     store_data;
    } xm_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        reg_addr_t dest;
        word_t     wdata;
    } mw_t;

endpackage

/* hdl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage import cpu_pkg::*; #(
    parameter int IMEM_ADDR_W = 12
) (
    input  logic                   clk,
    input  logic                   reset,
    input  word_t                  imem_data,
    input  logic                   redirect,
    input  word_t                  redirect_pc,
    input  logic                   load_stall,
    input  logic                   mem_busy,
    output logic [IMEM_ADDR_W-1:0] imem_addr,
    output fd_t                    fd
);

    word_t   pc;
    word_t   pc_plus_1;
    word_t   next_pc;
    opcode_e fetch_op;
    logic    is_jump;
    logic    advance;

    assign imem_addr = pc[IMEM_ADDR_W-1:0];
    assign pc_plus_1 = pc + 32'd1;

    // predecode j/jal straight off the instruction port
    assign fetch_op = opcode_e'(imem_data[fld_op_hi:fld_op_lo]);
    assign is_jump  = (fetch_op == op_j) || (fetch_op == op_jal);

    // bne from execute wins over a jump being fetched
    always_comb begin
        if (redirect)
            next_pc = redirect_pc;
        else if (is_jump)
            next_pc = word_t'(imem_data[fld_tgt_hi:0]);
        else
            next_pc = pc_plus_1;
    end

    // bus freeze holds everything, redirect beats the load interlock
    assign advance = !mem_busy && (redirect || !load_stall);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            fd.valid <= 1'b0;
        end else if (advance) begin
            pc           <= next_pc;
            // squash the fetched word on a taken bne
            fd.valid     <= !redirect;
            fd.pc_plus_1 <= pc_plus_1;
            fd.instr     <= imem_data;
        end
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  fd_t       fd,
    input  mw_t       mw,
    input  logic      redirect,
    input  logic      load_stall,
    input  logic      mem_busy,
    output dx_t       dx,
    output reg_addr_t rs_num_d,
    output reg_addr_t reg2_num_d
);

    opcode_e   op;
    ctrl_t     ctrl;
    reg_addr_t rd;
    reg_addr_t rs_num;
    reg_addr_t reg2_num;
    word_t     rs_val;
    word_t     reg2_val;
    logic      wr_en;
    dx_t       dx_next;
    // r1..r31, r0 is not stored
    word_t     regs [1:31];

    // ****************************************
    // fields and control
    // ****************************************
    assign op = opcode_e'(fd.instr[fld_op_hi:fld_op_lo]);
    assign rd = fd.instr[fld_rd_hi:fld_rd_lo];

    always_comb begin
        ctrl           = '0;
        ctrl.is_rtype  = (op == op_rtype);
        ctrl.is_addi   = (op == op_addi);
        ctrl.is_lw     = (op == op_lw);
        ctrl.is_sw     = (op == op_sw);
        ctrl.is_bne    = (op == op_bne);
        ctrl.is_jal    = (op == op_jal);
        ctrl.reg_write = ctrl.is_rtype | ctrl.is_addi | ctrl.is_lw | ctrl.is_jal;
    end

    // rs only for instructions that read it, keeps false interlocks away
    assign rs_num = (ctrl.is_rtype | ctrl.is_addi | ctrl.is_lw | ctrl.is_sw | ctrl.is_bne)
                  ? fd.instr[fld_rs_hi:fld_rs_lo] : '0;
    // second read port: rt for R-type, rd for sw and bne
    assign reg2_num = ctrl.is_rtype ? fd.instr[fld_rt_hi:fld_rt_lo]
                    : (ctrl.is_sw | ctrl.is_bne) ? rd : '0;

    // hazard unit only cares about a live instruction
    assign rs_num_d   = fd.valid ? rs_num : '0;
    assign reg2_num_d = fd.valid ? reg2_num : '0;

    // ****************************************
    // register file
    // ****************************************
    assign wr_en = mw.valid && mw.reg_write && (mw.dest != '0);

    // registers start out zero
    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[mw.dest] <= mw.wdata;
        end
    end

    // write-through from writeback in the same cycle
    assign rs_val = (rs_num == '0) ? '0
                  : (wr_en && mw.dest == rs_num) ? mw.wdata : regs[rs_num];
    assign reg2_val = (reg2_num == '0) ? '0
                    : (wr_en && mw.dest == reg2_num) ? mw.wdata : regs[reg2_num];

    // ****************************************
    // decode/execute register
    // ****************************************
    always_comb begin
        dx_next.valid     = fd.valid && !redirect && !load_stall;
        dx_next.ctrl      = ctrl;
        dx_next.pc_plus_1 = fd.pc_plus_1;
        dx_next.rd        = rd;
        dx_next.rs_num    = rs_num;
        dx_next.reg2_num  = reg2_num;
        dx_next.rs_val    = rs_val;
        dx_next.reg2_val  = reg2_val;
        // sign-extend the 16-bit immediate
        dx_next.imm = {{(31 - fld_imm_hi){fd.instr[fld_imm_hi]}}, fd.instr[fld_imm_hi:0]};
        // immediate forms all go through add
        dx_next.alu_op = ctrl.is_rtype ? alu_op_e'(fd.instr[fld_alu_hi:fld_alu_lo]) : alu_add;
        dx_next.shamt  = fd.instr[fld_shamt_hi:fld_shamt_lo];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dx.valid <= 1'b0;
        end else if (mem_busy) begin
            // frozen entry picks up writes it can no longer see via mw
            if (wr_en && mw.dest == dx.rs_num)
                dx.rs_val <= mw.wdata;
            if (wr_en && mw.dest == dx.reg2_num)
                dx.reg2_val <= mw.wdata;
        end else begin
            dx <= dx_next;
        end
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  dx_t   dx,
    input  mw_t   mw,
    input  logic  mem_busy,
    output xm_t   xm,
    output logic  redirect,
    output word_t redirect_pc
);

    reg_addr_t xm_dest;
    logic      xm_fwd;
    logic      mw_fwd;
    word_t     rs_fwd;
    word_t     reg2_fwd;
    word_t     alu_b;
    word_t     alu_res;
    word_t     result;

    // ****************************************
    // forwarding
    // ****************************************
    // jal in memory writes r31, not its rd field
    assign xm_dest = xm.ctrl.is_jal ? link_reg : xm.rd;
    // loads in memory have no data yet, interlock covers them
    assign xm_fwd = xm.valid && xm.ctrl.reg_write && !xm.ctrl.is_lw && (xm_dest != '0);
    assign mw_fwd = mw.valid && mw.reg_write && (mw.dest != '0);

    // nearest producer first
    assign rs_fwd = (xm_fwd && xm_dest == dx.rs_num) ? xm.result
                  : (mw_fwd && mw.dest == dx.rs_num) ? mw.wdata
                  : dx.rs_val;
    assign reg2_fwd = (xm_fwd && xm_dest == dx.reg2_num) ? xm.result
                    : (mw_fwd && mw.dest == dx.reg2_num) ? mw.wdata
                    : dx.reg2_val;

    // ****************************************
    // alu
    // ****************************************
    assign alu_b = (dx.ctrl.is_addi | dx.ctrl.is_lw | dx.ctrl.is_sw) ? dx.imm : reg2_fwd;

    always_comb begin
        case (dx.alu_op)
            alu_add: alu_res = rs_fwd + alu_b;
            alu_sub: alu_res = rs_fwd - alu_b;
            alu_and: alu_res = rs_fwd & alu_b;
            alu_or:  alu_res = rs_fwd | alu_b;
            // shifts take shamt, not operand b
            alu_sll: alu_res = rs_fwd << dx.shamt;
            alu_sra: alu_res = word_t'($signed(rs_fwd) >>> dx.shamt);
            default: alu_res = '0;
        endcase
    end

    // jal carries its return address
    assign result = dx.ctrl.is_jal ? dx.pc_plus_1 : alu_res;

    // bne rd, rs taken when they differ
    assign redirect    = dx.valid && dx.ctrl.is_bne && (rs_fwd != reg2_fwd);
    assign redirect_pc = dx.pc_plus_1 + dx.imm;

    // ****************************************
    // execute/memory register
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            xm.valid <= 1'b0;
        end else if (!mem_busy) begin
            xm.valid      <= dx.valid;
            xm.ctrl       <= dx.ctrl;
            xm.rd         <= dx.rd;
            xm.result     <= result;
            // sw stores rd, read on the second port
            xm.store_data <= reg2_fwd;
        end
    end

endmodule

/* hdl/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage import cpu_pkg::*; #(
    parameter int DMEM_ADDR_W = 12
) (
    input  logic                   clk,
    input  logic                   reset,
    input  xm_t                    xm,
    input  word_t                  wb_dat_i,
    input  logic                   wb_ack,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [DMEM_ADDR_W-1:0] wb_adr,
    output word_t                  wb_dat_o,
    output logic                   mem_busy,
    output mw_t                    mw
);

    logic mem_op;

    // ****************************************
    // wishbone master
    // ****************************************
    // one transfer per lw/sw, xm holds it steady until ack
    assign mem_op   = xm.valid && (xm.ctrl.is_lw || xm.ctrl.is_sw);
    assign wb_cyc   = mem_op;
    assign wb_stb   = mem_op;
    assign wb_we    = mem_op && xm.ctrl.is_sw;
    // word address from the low result bits
    assign wb_adr   = xm.result[DMEM_ADDR_W-1:0];
    assign wb_dat_o = xm.store_data;

    // waiting on the slave freezes the whole pipe
    assign mem_busy = mem_op && !wb_ack;

    // ****************************************
    // memory/writeback register
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            mw.valid <= 1'b0;
        end else if (mem_busy) begin
            // nothing retires while the bus is stalled
            mw.valid <= 1'b0;
        end else begin
            mw.valid     <= xm.valid;
            mw.reg_write <= xm.ctrl.reg_write;
            mw.dest      <= xm.ctrl.is_jal ? link_reg : xm.rd;
            // load data sampled on the ack edge
            mw.wdata     <= xm.ctrl.is_lw ? wb_dat_i : xm.result;
        end
    end

endmodule

/* hdl/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit import cpu_pkg::*; (
    input  dx_t       dx,
    input  xm_t       xm,
    input  reg_addr_t rs_num_d,
    input  reg_addr_t reg2_num_d,
    output logic      load_stall
);

    logic load_x_hit;
    logic load_m_hit;

    // load in execute, decode reads its target
    assign load_x_hit = dx.valid && dx.ctrl.is_lw && (dx.rd != '0)
                     && (dx.rd == rs_num_d || dx.rd == reg2_num_d);

    // load in memory, data not back until writeback
    assign load_m_hit = xm.valid && xm.ctrl.is_lw && (xm.rd != '0)
                     && (xm.rd == rs_num_d || xm.rd == reg2_num_d);

    // consumer waits in decode, then forwards from writeback
    assign load_stall = load_x_hit || load_m_hit;

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; #(
    parameter int IMEM_ADDR_W = 12,
    parameter int DMEM_ADDR_W = 12
) (
    input  logic                   clk,
    input  logic                   reset,
    // instruction port, combinational read
    output logic [IMEM_ADDR_W-1:0] imem_addr,
    input  word_t                  imem_data,
    // wishbone classic master
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [DMEM_ADDR_W-1:0] wb_adr,
    output word_t                  wb_dat_o,
    input  word_t                  wb_dat_i,
    input  logic                   wb_ack
);

    // stage to stage registers
    fd_t fd;
    dx_t dx;
    xm_t xm;
    mw_t mw;

    // control between stages
    logic      redirect;
    word_t     redirect_pc;
    logic      load_stall;
    logic      mem_busy;
    reg_addr_t rs_num_d;
    reg_addr_t reg2_num_d;

    // ****************************************
    // pipeline
    // ****************************************
    fetch_stage #(.IMEM_ADDR_W(IMEM_ADDR_W)) i_fetch (
        .clk, .reset, .imem_data, .redirect, .redirect_pc,
        .load_stall, .mem_busy, .imem_addr, .fd
    );

    decode_stage i_decode (
        .clk, .reset, .fd, .mw, .redirect, .load_stall,
        .mem_busy, .dx, .rs_num_d, .reg2_num_d
    );

    execute_stage i_execute (
        .clk, .reset, .dx, .mw, .mem_busy, .xm, .redirect, .redirect_pc
    );

    memory_stage #(.DMEM_ADDR_W(DMEM_ADDR_W)) i_memory (
        .clk, .reset, .xm, .wb_dat_i, .wb_ack, .wb_cyc, .wb_stb,
        .wb_we, .wb_adr, .wb_dat_o, .mem_busy, .mw
    );

    // load-use interlock
    hazard_unit i_hazard (
        .dx, .xm, .rs_num_d, .reg2_num_d, .load_stall
    );

endmodule

/* dv/cpu_assertions.sv */
`timescale 1ns/100ps

module cpu_assertions #(
    parameter int IMEM_ADDR_W = 12,
    parameter int DMEM_ADDR_W = 12
) (
    input logic                   clk,
    input logic                   reset,
    input logic [IMEM_ADDR_W-1:0] imem_addr,
    input logic                   wb_cyc,
    input logic                   wb_stb,
    input logic                   wb_we,
    input logic [DMEM_ADDR_W-1:0] wb_adr,
    input logic [31:0]            wb_dat_o,
    input logic                   wb_ack
);

    // count of failed assertions
    int failures = 0;

    // bus idle and fetch from 0 right after reset
    idle_after_reset: assert property (@(posedge clk) reset |=> !wb_cyc && !wb_stb && !wb_we)
        else begin
            failures++;
            $error("bus not idle after reset");
        end
    first_fetch_zero: assert property (@(posedge clk) reset |=> imem_addr == '0)
        else begin
            failures++;
            $error("first fetch address is not zero");
        end

    // request held steady until the slave acks
    hold_until_ack: assert property (@(posedge clk) disable iff (reset)
        wb_cyc && wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_we)
            && $stable(wb_adr) && $stable(wb_dat_o))
        else begin
            failures++;
            $error("request changed before wb_ack");
        end

endmodule

/* dv/cpu_monitor.sv */
`timescale 1ns/100ps

module cpu_monitor import cpu_pkg::*; #(
    parameter int DEPTH       = 4096,
    parameter int DMEM_ADDR_W = 12,
    parameter int HALT_PC     = 231,
    parameter int MAX_CYCLES  = 30000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   program_ready,
    input  word_t                  imem [0:DEPTH-1],
    input  word_t                  dmem [0:DEPTH-1],
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [DMEM_ADDR_W-1:0] wb_adr,
    input  word_t                  wb_dat_o,
    input  logic                   wb_ack,
    output logic                   finished,
    output int                     error_count,
    output int                     store_count,
    output int                     expected_count
);

    logic [DMEM_ADDR_W-1:0] exp_adr [$];
    word_t                  exp_dat [$];
    logic                   model_done;

    // ****************************************
    // instruction-set model
    // ****************************************
    task automatic run_model();
        word_t                  regs [0:31];
        word_t                  mem [0:DEPTH-1];
        word_t                  pc;
        word_t                  instr;
        word_t                  imm;
        word_t                  a;
        word_t                  b;
        word_t                  res;
        logic [4:0]             rd;
        logic [4:0]             rs;
        logic [DMEM_ADDR_W-1:0] addr;
        int                     steps;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < DEPTH; i++)
            mem[i] = dmem[i];
        pc = '0;
        steps = 0;
        while (pc != HALT_PC && steps < 100000) begin
            instr = imem[pc[$clog2(DEPTH)-1:0]];
            rd    = instr[26:22];
            rs    = instr[21:17];
            imm   = {{16{instr[15]}}, instr[15:0]};
            a     = regs[rs];
            b     = regs[rd];
            pc    = pc + 32'd1;
            case (instr[31:27])
                5'b00000: begin
                    case (instr[6:2])
                        5'd0: res = a + regs[instr[16:12]];
                        5'd1: res = a - regs[instr[16:12]];
                        5'd2: res = a & regs[instr[16:12]];
                        5'd3: res = a | regs[instr[16:12]];
                        5'd4: res = a << instr[11:7];
                        5'd5: res = $signed(a) >>> instr[11:7];
                        default: res = '0;
                    endcase
                    if (rd != 0) regs[rd] = res;
                end
                5'b00101: if (rd != 0) regs[rd] = a + imm;
                5'b01000: begin
                    addr = DMEM_ADDR_W'(a + imm);
                    if (rd != 0) regs[rd] = mem[addr];
                end
                5'b00111: begin
                    addr = DMEM_ADDR_W'(a + imm);
                    mem[addr] = b;
                    exp_adr.push_back(addr);
                    exp_dat.push_back(b);
                end
                // pc already points past the branch
                5'b00010: if (a != b) pc = pc + imm;
                5'b00001: pc = {5'b0, instr[26:0]};
                5'b00011: begin
                    regs[31] = pc;
                    pc = {5'b0, instr[26:0]};
                end
                default: ;
            endcase
            steps++;
        end
        if (pc != HALT_PC) begin
            $display("model never reached the halt loop");
            error_count++;
        end
        expected_count = exp_adr.size();
    endtask

    // ****************************************
    // store comparison
    // ****************************************
    always @(posedge clk) begin
        if (!reset && model_done && wb_cyc && wb_stb && wb_we && wb_ack) begin
            if (store_count >= expected_count) begin
                $display("store %0d to %h was not expected by the model", store_count, wb_adr);
                error_count++;
            end else begin
                if (wb_adr !== exp_adr[store_count]) begin
                    $display("MISMATCH wb_adr store %0d: got %h expected %h",
                             store_count, wb_adr, exp_adr[store_count]);
                    error_count++;
                end
                if (wb_dat_o !== exp_dat[store_count]) begin
                    $display("MISMATCH wb_dat_o store %0d: got %h expected %h",
                             store_count, wb_dat_o, exp_dat[store_count]);
                    error_count++;
                end
            end
            store_count++;
        end
    end

    initial begin
        int cycles;
        finished       = 1'b0;
        model_done     = 1'b0;
        error_count    = 0;
        store_count    = 0;
        expected_count = 0;
        cycles         = 0;
        while (program_ready !== 1'b1 && cycles < 100) begin
            #1;
            cycles++;
        end
        if (program_ready !== 1'b1) begin
            $display("program was never generated");
            error_count++;
        end
        run_model();
        model_done = 1'b1;
        // last expected store is r31
        cycles = 0;
        while (store_count < expected_count && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (store_count < expected_count) begin
            $display("program did not finish: %0d of %0d stores seen", store_count,
                     expected_count);
            error_count++;
        end
        finished = 1'b1;
    end

endmodule

/* dv/tb_cpu.sv */
`timescale 1ns/100ps

module tb_cpu import cpu_pkg::*; ();

    localparam int IMEM_ADDR_W = 12;
    localparam int DMEM_ADDR_W = 12;
    localparam int DEPTH       = 4096;
    localparam int PROG_LEN    = 200;
    localparam int HALT_PC     = PROG_LEN + 31;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    word_t                  imem_data;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [DMEM_ADDR_W-1:0] wb_adr;
    word_t                  wb_dat_o;
    word_t                  wb_dat_i;
    logic                   wb_ack;
    word_t                  imem [0:DEPTH-1];
    word_t                  dmem [0:DEPTH-1];
    logic                   program_ready;
    logic                   finished;
    int                     error_count;
    int                     store_count;
    int                     expected_count;
    int                     wait_left;
    int                     seed;

    always #10 clk = !clk;

    cpu_top #(.IMEM_ADDR_W(IMEM_ADDR_W), .DMEM_ADDR_W(DMEM_ADDR_W)) i_dut (
        .clk, .reset, .imem_addr, .imem_data, .wb_cyc, .wb_stb, .wb_we,
        .wb_adr, .wb_dat_o, .wb_dat_i, .wb_ack
    );

    bind cpu_top cpu_assertions #(.IMEM_ADDR_W(IMEM_ADDR_W), .DMEM_ADDR_W(DMEM_ADDR_W))
        i_assertions (.clk, .reset, .imem_addr, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
                      .wb_dat_o, .wb_ack);

    cpu_monitor #(.DEPTH(DEPTH), .DMEM_ADDR_W(DMEM_ADDR_W), .HALT_PC(HALT_PC)) i_monitor (
        .clk, .reset, .program_ready, .imem, .dmem, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
        .wb_dat_o, .wb_ack, .finished, .error_count, .store_count, .expected_count
    );

    // combinational instruction read
    assign imem_data = imem[imem_addr];

    // mostly r0..r7 so dependencies are dense
    function automatic reg_addr_t pick_reg();
        word_t r;
        r = $random(seed);
        return r[5] ? r[4:0] : {2'b00, r[2:0]};
    endfunction

    // ****************************************
    // program and data
    // ****************************************
    task automatic make_program();
        word_t r;
        int    tgt;
        for (int i = 0; i < DEPTH; i++) begin
            dmem[i] = $random(seed);
            // unknown opcode, a no-op tagged with its address
            imem[i] = {5'h1f, 27'(i)};
        end
        for (int pc = 0; pc < PROG_LEN; pc++) begin
            r = $random(seed);
            // forward only, never past the store block
            tgt = pc + 1 + int'(r[10:8]);
            if (tgt > PROG_LEN) tgt = PROG_LEN;
            case (r[3:0])
                4'd7, 4'd8, 4'd9:
                    imem[pc] = {op_addi, pick_reg(), pick_reg(), 1'b0, r[31:16]};
                4'd10, 4'd11:
                    imem[pc] = {op_lw, pick_reg(), pick_reg(), 1'b0, r[31:16]};
                4'd12: imem[pc] = {op_sw, pick_reg(), pick_reg(), 1'b0, r[31:16]};
                4'd13: imem[pc] = {op_bne, pick_reg(), pick_reg(), 1'b0, 16'(tgt - pc - 1)};
                4'd14: imem[pc] = {op_j, 27'(tgt)};
                4'd15: imem[pc] = {op_jal, 27'(tgt)};
                default: imem[pc] = {op_rtype, pick_reg(), pick_reg(), pick_reg(), r[15:11],
                                     5'(r[31:24] % 6), 2'b00};
            endcase
        end
        // dump r1..r31 to fixed addresses, then spin
        for (int n = 1; n < 32; n++)
            imem[PROG_LEN + n - 1] = {op_sw, 5'(n), 5'd0, 1'b0, 16'h0f00 + 16'(n)};
        imem[HALT_PC] = {op_j, 27'(HALT_PC)};
    endtask

    // ****************************************
    // wishbone slave, 0 to 3 wait states
    // ****************************************
    always @(posedge clk) begin
        // a write completes on the edge that sees ack
        if (wb_ack && wb_cyc && wb_stb && wb_we)
            dmem[wb_adr] = wb_dat_o;
        #2;
        wb_ack = 1'b0;
        if (reset || !(wb_cyc && wb_stb)) begin
            wait_left = -1;
        end else begin
            if (wait_left < 0) wait_left = $random(seed) & 3;
            if (wait_left == 0) begin
                wb_ack    = 1'b1;
                wb_dat_i  = dmem[wb_adr];
                // next request draws a fresh wait count
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    initial begin
        int cycles;
        int total;
        seed          = 32'h031b_8d63;
        reset         = 1'b1;
        wb_ack        = 1'b0;
        wb_dat_i      = '0;
        wait_left     = -1;
        program_ready = 1'b0;
        make_program();
        program_ready = 1'b1;
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        cycles = 0;
        while (!finished && cycles < 40000) begin
            @(posedge clk);
            cycles++;
        end
        total = error_count + i_dut.i_assertions.failures;
        if (!finished) begin
            $display("monitor never reported the end of the run");
            total++;
        end
        $display("errors %0d, assertion failures %0d, stores %0d of %0d", total,
                 i_dut.i_assertions.failures, store_count, expected_count);
        if (total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* build.f */
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/cpu_top.sv
dv/cpu_assertions.sv
dv/cpu_monitor.sv
dv/tb_cpu.sv

/* Makefile */
SIM      := verilator
TOP      := tb_cpu
FLIST    := build.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FLIST))
PASS_MSG := RESULT: PASS

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
